// ==== tb.f ====
source/lookup_pkg.sv
source/config_pkg.sv
source/config_decoder.sv
source/cam_cell.sv
source/match_encoder.sv
source/action_table.sv
source/lookup_sequencer.sv
source/lookup_engine.sv
bench/lookup_engine_chk.sv
bench/tb_lookup_engine.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the lookup engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lookup_engine -f tb.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

// ==== bench/tb_lookup_engine.sv ====
// directed and random testbench for the CAM lookup engine that runs from the tb.f file list
`default_nettype none
`timescale 1ns/1ps

module tb_lookup_engine;

    localparam int depth           = 16;
    localparam int num_tests       = 6;
    localparam int watchdog_cycles = num_tests * 60 + 2000;
    localparam logic [31:0] miss_action = 32'h0000_003f;

    logic                      clk = 1'b0;
    logic                      rst_n;
    lookup_pkg::key_t          extract_key;
    lookup_pkg::key_t          extract_mask;
    logic                      key_valid;
    lookup_pkg::phv_t          phv_in;
    config_pkg::config_cmd_t   config_in;
    lookup_pkg::action_t       action;
    logic                      action_valid;
    lookup_pkg::phv_t          phv_out;
    logic                      lookup_ready;
    config_pkg::config_cmd_t   config_out;

    // reference model of the tables
    lookup_pkg::key_t          model_entry [depth];
    logic                      model_valid [depth];
    lookup_pkg::action_t       model_action [depth];

    int                        error_count  = 0;
    int                        tests_run    = 0;
    int                        tests_failed = 0;
    logic [31:0]               rng_state;

    lookup_engine dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .extract_key  (extract_key),
        .extract_mask (extract_mask),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .config_in    (config_in),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out),
        .lookup_ready (lookup_ready),
        .config_out   (config_out)
    );

    always #4 clk = ~clk;

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic config_pkg::config_cmd_t make_cmd(input logic [4:0] stage,
            input logic [2:0] lookup, input logic [15:0] flag,
            input config_pkg::target_e target, input logic [7:0] index,
            input logic [31:0] payload);
        config_pkg::config_cmd_t cmd;
        cmd.valid        = 1'b1;
        cmd.stage_id     = stage;
        cmd.lookup_id    = lookup;
        cmd.control_flag = flag;
        cmd.target       = target;
        cmd.index        = index;
        cmd.payload      = payload;
        return cmd;
    endfunction

    task automatic check_value(input string name, input logic [71:0] got,
            input logic [71:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, error_count - errors_before);
        end
    endtask

    // lowest valid entry whose unmasked bits equal the key wins
    task automatic model_lookup(input lookup_pkg::key_t key, input lookup_pkg::key_t mask,
            output logic hit, output lookup_pkg::action_t act);
        hit = 1'b0;
        act = miss_action;
        for (int i = 0; i < depth; i++) begin
            if (!hit && model_valid[i] && (model_entry[i] | mask) == (key | mask)) begin
                hit = 1'b1;
                act = model_action[i];
            end
        end
    endtask

    // one command beat; returns right after the edge that samples it
    task automatic send_config(input config_pkg::config_cmd_t cmd);
        @(posedge clk);
        config_in <= cmd;
        @(posedge clk);
        config_in <= '0;
    endtask

    task automatic write_entry(input logic [7:0] index, input lookup_pkg::key_t key);
        send_config(make_cmd(5'd0, 3'd2, 16'hf2f1, config_pkg::cam_entry, index, {8'h00, key}));
        model_entry[index[3:0]] = key;
        model_valid[index[3:0]] = 1'b1;
    endtask

    task automatic write_action(input logic [7:0] index, input lookup_pkg::action_t act);
        send_config(make_cmd(5'd0, 3'd2, 16'hf2f1, config_pkg::action_entry, index, act));
        model_action[index[3:0]] = act;
    endtask

    // foreign command must come out unchanged for one cycle
    task automatic send_foreign(input config_pkg::config_cmd_t cmd);
        send_config(cmd);
        @(negedge clk);
        check_value("config_out", 72'(config_out), 72'(cmd));
        @(negedge clk);
        check_value("config_out.valid", 72'(config_out.valid), 72'd0);
    endtask

    task automatic lookup_and_check(input lookup_pkg::key_t key, input lookup_pkg::key_t mask,
            input lookup_pkg::phv_t phv);
        logic                exp_hit;
        lookup_pkg::action_t exp_act;
        int                  cycles;
        model_lookup(key, mask, exp_hit, exp_act);
        @(negedge clk);
        while (!lookup_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        extract_key  <= key;
        extract_mask <= mask;
        phv_in       <= phv;
        key_valid    <= 1'b1;
        @(posedge clk);
        key_valid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (!action_valid) begin
                check_value("lookup_ready", 72'(lookup_ready), 72'd0);
            end
        end while (!action_valid && cycles < 8);
        assert (action_valid) else begin
            $display("no action_valid within 8 cycles of lookup for key 0x%h", key);
            error_count++;
        end
        if (action_valid) begin
            check_value("action", 72'(action), 72'(exp_act));
            check_value("phv_out", 72'(phv_out), 72'(phv));
            check_value("latency", 72'(cycles), exp_hit ? 72'd3 : 72'd1);
            check_value("lookup_ready", 72'(lookup_ready), 72'd1);
            @(negedge clk);
            check_value("action_valid", 72'(action_valid), 72'd0);
        end
    endtask

    task automatic test_miss_after_reset();
        int start;
        start = error_count;
        @(negedge clk);
        check_value("action_valid", 72'(action_valid), 72'd0);
        check_value("config_out.valid", 72'(config_out.valid), 72'd0);
        check_value("lookup_ready", 72'(lookup_ready), 72'd1);
        lookup_and_check(24'h000000, 24'h000000, 64'h0123_4567_89ab_cdef);
        lookup_and_check(24'hffffff, 24'hffffff, 64'hfeed_face_0000_0001);
        report_test("miss_after_reset", start);
    endtask

    task automatic test_hit();
        int start;
        start = error_count;
        write_entry(8'd1, 24'habcdef);
        write_action(8'd1, 32'hdead_0001);
        repeat (2) @(posedge clk);
        lookup_and_check(24'habcdef, 24'h000000, 64'h1111_2222_3333_4444);
        report_test("hit", start);
    endtask

    task automatic test_mask();
        int start;
        start = error_count;
        write_entry(8'd2, 24'h5a5a5a);
        write_action(8'd2, 32'hcafe_0002);
        // key differs in bits 5 and 6
        lookup_and_check(24'h5a5a3a, 24'h0000f0, 64'h0000_0000_0000_0a5a);
        lookup_and_check(24'h5a5a3a, 24'h0000b0, 64'h0000_0000_0000_0b5a);
        report_test("mask", start);
    endtask

    task automatic test_priority();
        int start;
        start = error_count;
        write_entry(8'd7, 24'h1234ff);
        write_action(8'd7, 32'h7777_0007);
        write_entry(8'd3, 24'h123400);
        write_action(8'd3, 32'h3333_0003);
        lookup_and_check(24'h123455, 24'h0000ff, 64'h5555_0000_0000_0003);
        report_test("priority", start);
    endtask

    task automatic test_foreign_and_busy();
        int start;
        start = error_count;
        write_entry(8'd9, 24'h0f0f0f);
        write_action(8'd9, 32'hbeef_0009);
        send_foreign(make_cmd(5'd1, 3'd2, 16'hf2f1, config_pkg::cam_entry, 8'd9, 32'h0077_7777));
        send_foreign(make_cmd(5'd0, 3'd3, 16'hf2f1, config_pkg::action_entry, 8'd9,
            32'h1111_1111));
        send_foreign(make_cmd(5'd0, 3'd2, 16'hf2f0, config_pkg::cam_entry, 8'd4, 32'h0033_3333));
        lookup_and_check(24'h777777, 24'h000000, 64'h0000_0000_0000_0777);
        lookup_and_check(24'h0f0f0f, 24'h000000, 64'h0000_0000_0000_0f0f);
        lookup_and_check(24'h333333, 24'h000000, 64'h0000_0000_0000_0333);
        // a missing key held high while busy must be ignored
        @(negedge clk);
        while (!lookup_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        extract_key  <= 24'h0f0f0f;
        extract_mask <= 24'h000000;
        phv_in       <= 64'haaaa_0000_0000_0001;
        key_valid    <= 1'b1;
        @(posedge clk);
        extract_key <= 24'h999999;
        phv_in      <= 64'hbbbb_0000_0000_0002;
        repeat (2) @(posedge clk);
        key_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("action_valid", 72'(action_valid), 72'd1);
        check_value("action", 72'(action), 72'(32'hbeef_0009));
        check_value("phv_out", 72'(phv_out), 72'(64'haaaa_0000_0000_0001));
        repeat (4) begin
            @(negedge clk);
            check_value("action_valid", 72'(action_valid), 72'd0);
        end
        report_test("foreign_and_busy", start);
    endtask

    task automatic test_random();
        int          start;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  sel;
        start = error_count;
        for (int i = 0; i < depth; i++) begin
            write_action(8'(i), next_rand());
        end
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            a = next_rand();
            b = next_rand();
            sel = r[11:8];
            if (r[1:0] == 2'd0) begin
                write_entry(r[15:8], a[23:0]);
            end else if (r[1:0] == 2'd1) begin
                write_action(r[15:8], a);
            end else if (r[2]) begin
                lookup_and_check(a[23:0], a[23:0] & b[23:0], {a, b});
            end else begin
                // key near a stored entry that differs only in masked bits
                lookup_and_check(model_entry[sel] ^ (a[23:0] & b[23:0]), b[23:0], {b, a});
            end
        end
        report_test("random", start);
    endtask

    initial begin
        rst_n        <= 1'b0;
        extract_key  <= '0;
        extract_mask <= '0;
        key_valid    <= 1'b0;
        phv_in       <= '0;
        config_in    <= '0;
        rng_state = 32'd18620;
        for (int i = 0; i < depth; i++) begin
            model_entry[i]  = '0;
            model_valid[i]  = 1'b0;
            model_action[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_miss_after_reset();
        test_hit();
        test_mask();
        test_priority();
        test_foreign_and_busy();
        test_random();
        $display("%0d tests run, %0d failed, %0d failed checks",
            tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles + 4) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/lookup_engine_chk.sv ====
// concurrent assertions on strobes and table writes, bound into every lookup_engine
`default_nettype none
`timescale 1ns/1ps

module lookup_engine_chk #(
    parameter int DEPTH     = 16,
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2
) (
    input wire                          clk,
    input wire                          rst_n,
    input wire                          action_valid,
    input wire [DEPTH-1:0]              cam_we,
    input wire                          act_we,
    input wire config_pkg::config_cmd_t config_in,
    input wire config_pkg::config_cmd_t config_out
);

    logic accepted;

    // command addressed to this engine
    assign accepted = config_in.valid
                   && (config_in.stage_id == 5'(STAGE_ID))
                   && (config_in.lookup_id == 3'(LOOKUP_ID))
                   && (config_in.control_flag == config_pkg::CONTROL_FLAG);

    action_single : assert property (@(posedge clk) disable iff (!rst_n)
        action_valid |=> !action_valid)
        else $error("action_valid high on two consecutive cycles");

    cam_we_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(cam_we))
        else $error("more than one cam_we bit set");

    // one command writes one table
    we_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
        !((|cam_we) && act_we))
        else $error("cam_we and act_we set together");

    no_forward : assert property (@(posedge clk) disable iff (!rst_n)
        accepted |=> !config_out.valid)
        else $error("accepted command forwarded on config_out");

endmodule

bind lookup_engine lookup_engine_chk #(
    .DEPTH     (DEPTH),
    .STAGE_ID  (STAGE_ID),
    .LOOKUP_ID (LOOKUP_ID)
) u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .action_valid (action_valid),
    .cam_we       (cam_we),
    .act_we       (act_we),
    .config_in    (config_in),
    .config_out   (config_out)
);

`default_nettype wire

// ==== source/lookup_engine.sv ====
// match stage top level; CAM lookup with action table and configuration decode
`default_nettype none
`timescale 1ns/1ps

module lookup_engine #(
    parameter int DEPTH     = 16,
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire lookup_pkg::key_t        extract_key,
    input  wire lookup_pkg::key_t        extract_mask,
    input  wire                          key_valid,
    input  wire lookup_pkg::phv_t        phv_in,
    input  wire config_pkg::config_cmd_t config_in,
    output lookup_pkg::action_t          action,
    output logic                         action_valid,
    output lookup_pkg::phv_t             phv_out,
    output logic                         lookup_ready,
    output config_pkg::config_cmd_t      config_out
);

    // write side
    logic [DEPTH-1:0]         cam_we;
    lookup_pkg::key_t         cam_data;
    logic                     act_we;
    config_pkg::table_index_t act_addr;
    lookup_pkg::action_t      act_data;

    // lookup side
    logic [DEPTH-1:0]         hits;
    logic                     compare_en;
    logic                     match;
    config_pkg::table_index_t match_addr;
    lookup_pkg::action_t      table_action;

    config_decoder #(
        .DEPTH     (DEPTH),
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .config_in  (config_in),
        .config_out (config_out),
        .cam_we     (cam_we),
        .cam_data   (cam_data),
        .act_we     (act_we),
        .act_addr   (act_addr),
        .act_data   (act_data)
    );

    for (genvar i = 0; i < DEPTH; i++) begin : g_cell
        cam_cell u_cell (
            .clk        (clk),
            .rst_n      (rst_n),
            .we         (cam_we[i]),
            .entry_in   (cam_data),
            .key        (extract_key),
            .mask       (extract_mask),
            .compare_en (compare_en),
            .hit        (hits[i])
        );
    end

    match_encoder #(
        .DEPTH (DEPTH)
    ) u_encoder (
        .hits       (hits),
        .match      (match),
        .match_addr (match_addr)
    );

    // read address comes straight from the encoder
    action_table #(
        .DEPTH (DEPTH)
    ) u_table (
        .clk     (clk),
        .we      (act_we),
        .wr_addr (act_addr),
        .wr_data (act_data),
        .rd_addr (match_addr),
        .rd_data (table_action)
    );

    lookup_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .match        (match),
        .table_action (table_action),
        .compare_en   (compare_en),
        .lookup_ready (lookup_ready),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

endmodule

`default_nettype wire

// ==== source/lookup_sequencer.sv ====
// lookup FSM that gates the compare, holds the PHV and emits the resulting action
`default_nettype none
`timescale 1ns/1ps

module lookup_sequencer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      key_valid,
    input  wire lookup_pkg::phv_t    phv_in,
    input  wire                      match,
    input  wire lookup_pkg::action_t table_action,
    output logic                     compare_en,
    output logic                     lookup_ready,
    output lookup_pkg::action_t      action,
    output logic                     action_valid,
    output lookup_pkg::phv_t         phv_out
);

    lookup_pkg::lookup_state_e state;
    lookup_pkg::phv_t          phv_hold;
    logic                      emit_miss;
    logic                      emit_hit;

    // strobes while busy are dropped
    assign lookup_ready = (state == lookup_pkg::idle);
    assign compare_en   = key_valid && lookup_ready;

    // miss is known one cycle after the compare
    assign emit_miss = (state == lookup_pkg::wait_match) && !match;
    assign emit_hit  = (state == lookup_pkg::emit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= lookup_pkg::idle;
            action_valid <= 1'b0;
        end else begin
            action_valid <= emit_miss || emit_hit;
            case (state)
                lookup_pkg::idle: begin
                    if (compare_en) begin
                        state <= lookup_pkg::wait_match;
                    end
                end
                lookup_pkg::wait_match: begin
                    state <= match ? lookup_pkg::wait_read : lookup_pkg::idle;
                end
                // table read registers during this cycle
                lookup_pkg::wait_read: begin
                    state <= lookup_pkg::emit;
                end
                lookup_pkg::emit: begin
                    state <= lookup_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (compare_en) begin
            phv_hold <= phv_in;
        end
        if (emit_miss) begin
            action  <= lookup_pkg::DEFAULT_ACTION;
            phv_out <= phv_hold;
        end else if (emit_hit) begin
            action  <= table_action;
            phv_out <= phv_hold;
        end
    end

endmodule

`default_nettype wire

// ==== source/action_table.sv ====
// action memory with one write port and a read port registered every cycle
`default_nettype none
`timescale 1ns/1ps

module action_table #(
    parameter int DEPTH = 16
) (
    input  wire                           clk,
    input  wire                           we,
    input  wire config_pkg::table_index_t wr_addr,
    input  wire lookup_pkg::action_t      wr_data,
    input  wire config_pkg::table_index_t rd_addr,
    output lookup_pkg::action_t           rd_data
);

    localparam int IDX_W = $clog2(DEPTH);

    lookup_pkg::action_t mem [DEPTH];

    // addresses wrap at DEPTH
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    // old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[IDX_W-1:0]];
    end

endmodule

`default_nettype wire

// ==== source/match_encoder.sv ====
// combinational priority encoder from the CAM hit vector to match flag and index
`default_nettype none
`timescale 1ns/1ps

module match_encoder #(
    parameter int DEPTH = 16
) (
    input  wire [DEPTH-1:0]          hits,
    output logic                     match,
    output config_pkg::table_index_t match_addr
);

    assign match = |hits;

    // scan from the top so the lowest hit wins
    always_comb begin
        match_addr = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (hits[i]) begin
                match_addr = config_pkg::table_index_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cam_cell.sv ====
// one binary CAM entry with valid bit and registered masked compare
`default_nettype none
`timescale 1ns/1ps

module cam_cell (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   we,
    input  wire lookup_pkg::key_t entry_in,
    input  wire lookup_pkg::key_t key,
    input  wire lookup_pkg::key_t mask,
    input  wire                   compare_en,
    output logic                  hit
);

    lookup_pkg::key_t entry;
    logic             entry_valid;
    logic             key_eq;

    // only bits not masked out take part
    assign key_eq = ((entry ^ key) & ~mask) == '0;

    always_ff @(posedge clk) begin
        if (we) begin
            entry <= entry_in;
        end
    end

    // hit holds until the next compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= 1'b0;
            hit         <= 1'b0;
        end else begin
            if (we) begin
                entry_valid <= 1'b1;
            end
            if (compare_en) begin
                hit <= entry_valid && key_eq;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/config_decoder.sv ====
// decodes configuration commands into table write strobes and forwards foreign ones
`default_nettype none
`timescale 1ns/1ps

module config_decoder #(
    parameter int DEPTH     = 16,
    parameter int STAGE_ID  = 0,
    parameter int LOOKUP_ID = 2
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire config_pkg::config_cmd_t config_in,
    output config_pkg::config_cmd_t      config_out,
    output logic [DEPTH-1:0]             cam_we,
    output lookup_pkg::key_t             cam_data,
    output logic                         act_we,
    output config_pkg::table_index_t     act_addr,
    output lookup_pkg::action_t          act_data
);

    localparam int IDX_W = $clog2(DEPTH);

    logic             for_us;
    logic [DEPTH-1:0] cam_sel;

    // stage, lookup and flag must all agree
    assign for_us = (config_in.stage_id == 5'(STAGE_ID))
                 && (config_in.lookup_id == 3'(LOOKUP_ID))
                 && (config_in.control_flag == config_pkg::CONTROL_FLAG);

    // one-hot cell select with the index taken modulo DEPTH
    always_comb begin
        cam_sel = '0;
        cam_sel[config_in.index[IDX_W-1:0]] = 1'b1;
    end

    // strobes and forwarded commands last one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cam_we     <= '0;
            act_we     <= 1'b0;
            config_out <= '0;
        end else begin
            cam_we     <= '0;
            act_we     <= 1'b0;
            config_out <= '0;
            if (config_in.valid) begin
                if (!for_us) begin
                    config_out <= config_in;
                end else if (config_in.target == config_pkg::cam_entry) begin
                    cam_we <= cam_sel;
                end else begin
                    act_we <= 1'b1;
                end
            end
        end
    end

    // write data is only meaningful alongside a strobe
    always_ff @(posedge clk) begin
        if (config_in.valid && for_us) begin
            cam_data <= config_in.payload[lookup_pkg::KEY_W-1:0];
            act_addr <= config_in.index;
            act_data <= config_in.payload;
        end
    end

endmodule

`default_nettype wire

// ==== source/config_pkg.sv ====
// configuration command format and control constants for the table write path
`default_nettype none

package config_pkg;

    // used modulo the table depth
    typedef logic [7:0] table_index_t;

    typedef enum logic {
        cam_entry    = 1'b0,
        action_entry = 1'b1
    } target_e;

    // one single-beat command, 66 bits
    typedef struct packed {
        logic         valid;
        logic [4:0]   stage_id;
        logic [2:0]   lookup_id;
        logic [15:0]  control_flag;
        target_e      target;
        table_index_t index;
        logic [31:0]  payload;
    } config_cmd_t;

    // marks a command meant for a lookup engine
    localparam logic [15:0] CONTROL_FLAG = 16'hf2f1;

endpackage

`default_nettype wire

// ==== source/lookup_pkg.sv ====
// lookup datapath widths, value types and lookup FSM states for the match stage
`default_nettype none

package lookup_pkg;

    // datapath widths
    localparam int KEY_W    = 24;
    localparam int ACTION_W = 32;
    localparam int PHV_W    = 64;

    // key or mask; a set mask bit makes that key bit a don't-care
    typedef logic [KEY_W-1:0]    key_t;
    typedef logic [ACTION_W-1:0] action_t;
    typedef logic [PHV_W-1:0]    phv_t;

    // returned on a miss
    localparam action_t DEFAULT_ACTION = 32'h0000_003f;

    // lookup FSM
    typedef enum logic [1:0] {
        idle       = 2'd0,
        wait_match = 2'd1,
        wait_read  = 2'd2,
        emit       = 2'd3
    } lookup_state_e;

endpackage

`default_nettype wire
